// ==== rtl/cu_defines.svh ====
`ifndef CU_DEFINES_SVH
`define CU_DEFINES_SVH

// instruction word
`define CU_WORD_W 32

// class field, bits 27..25 of the instruction
`define CU_CLASS_HI 27
`define CU_CLASS_LO 25
`define CU_CLASS_W  (`CU_CLASS_HI - `CU_CLASS_LO + 1)

// class codes kept by this control unit
`define CU_CODE_DPSHIFT 3'b000
`define CU_CODE_DPIMM   3'b001
`define CU_CODE_BRANCH  3'b101

// set-flags bit of data-processing instructions
`define CU_SBIT 20

// link bit of branch instructions
`define CU_LBIT 24

// state register width
`define CU_STATE_W 4

// alu operation field of the control word
`define CU_ALUOP_W 5

`endif

// ==== rtl/cuPkg.sv ====
package cuPkg;

`include "cu_defines.svh"

	// raw instruction as held in the IR
	typedef logic [`CU_WORD_W-1:0] instrWord_t;

	typedef enum logic [1:0] {
		dataImm     = 2'd0,
		dataShift   = 2'd1,
		branch      = 2'd2,
		unsupported = 2'd3
	} instrClass_t;

	// fields of the instruction the FSM and the microcode care about
	typedef struct packed {
		instrClass_t instrClass;
		logic        sBit;
		logic        lBit;
	} decodedInstr_t;

	// state codes follow the microprogram numbering
	typedef enum logic [`CU_STATE_W-1:0] {
		reset       = 4'd0,
		fetchAddr   = 4'd1,
		fetchReq    = 4'd2,
		fetchWait   = 4'd3,
		decode      = 4'd4,
		dpImmAlu    = 4'd5,
		dpImmWrite  = 4'd6,
		dpShift     = 4'd7,
		branchCalc  = 4'd8,
		branchWrite = 4'd9,
		branchLink  = 4'd10
	} cuState_t;

	typedef struct packed {
		// load strobes
		logic                   rfLd;
		logic                   irLd;
		logic                   marLd;
		logic                   frLd;

		// memory interface
		logic                   rw;
		logic                   mov;
		logic [1:0]             typeData;

		// datapath mux selects
		logic [1:0]             maSel;
		logic [1:0]             mbSel;
		logic [2:0]             mcSel;
		logic                   md;
		logic [1:0]             mfSel;
		logic                   mh;
		logic [1:0]             miSel;
		logic [1:0]             mjSel;

		// immediate extender
		logic                   e;

		// shifter mode
		logic [2:0]             tSel;

		// status select, S5 is the msb
		logic [5:0]             sSel;

		logic [`CU_ALUOP_W-1:0] aluOp;
	} ctrlWord_t;

	// every strobe low, every select at zero
	localparam ctrlWord_t ctrlIdle = '0;

endpackage

// ==== rtl/instrDecoder.sv ====
`timescale 1ns/1ps

`include "cu_defines.svh"

module instrDecoder
	import cuPkg::*;
(
	input  instrWord_t    ir,
	output decodedInstr_t dec
);

	logic [`CU_CLASS_W-1:0] classCode;
	instrClass_t            instrClass;
	logic                   sBit;
	logic                   lBit;

	assign classCode = ir[`CU_CLASS_HI:`CU_CLASS_LO];

	// only three class codes have a microprogram here
	always_comb
	begin
		case (classCode)
			`CU_CODE_DPIMM:
				instrClass = dataImm;
			`CU_CODE_DPSHIFT:
				instrClass = dataShift;
			`CU_CODE_BRANCH:
				instrClass = branch;
			// load/store and coprocessor codes land here
			default:
				instrClass = unsupported;
		endcase
	end

	// S only matters for data processing, L only for branch
	assign sBit = ir[`CU_SBIT];
	assign lBit = ir[`CU_LBIT];

	always_comb
	begin
		dec.instrClass = instrClass;
		dec.sBit = sBit;
		dec.lBit = lBit;
	end

endmodule

// ==== rtl/sequencer.sv ====
`timescale 1ns/1ps

module sequencer
	import cuPkg::*;
(
	input  logic          CLK,
	input  logic          arstN,
	input  decodedInstr_t dec,
	input  logic          cond,
	input  logic          moc,
	output cuState_t      state
);

	cuState_t nextState;
	cuState_t entryState;

	// first execute state for the decoded class
	always_comb
	begin
		case (dec.instrClass)
			dataImm:
				entryState = dpImmAlu;
			dataShift:
				entryState = dpShift;
			branch:
			begin
				// link first saves the return address
				if (dec.lBit)
					entryState = branchLink;
				else
					entryState = branchCalc;
			end
			default:
				entryState = fetchAddr;
		endcase
	end

	always_comb
	begin
		nextState = state;
		case (state)
			reset:
				nextState = fetchAddr;
			fetchAddr:
				nextState = fetchReq;
			fetchReq:
				nextState = fetchWait;
			// stay here until memory reports the read complete
			fetchWait:
			begin
				if (moc)
					nextState = decode;
			end
			// a failed condition skips execution entirely
			decode:
			begin
				if (cond)
					nextState = entryState;
				else
					nextState = fetchAddr;
			end
			dpImmAlu:
				nextState = dpImmWrite;
			branchLink:
				nextState = branchCalc;
			branchCalc:
				nextState = branchWrite;
			dpImmWrite, dpShift, branchWrite:
				nextState = fetchAddr;
			// unused codes recover through a new fetch
			default:
				nextState = fetchAddr;
		endcase
	end

	always_ff @(posedge CLK or negedge arstN)
	begin
		if (!arstN)
			state <= reset;
		else
			state <= nextState;
	end

endmodule

// ==== rtl/microcodeDecode.sv ====
`timescale 1ns/1ps

module microcodeDecode
	import cuPkg::*;
(
	input  cuState_t      state,
	input  decodedInstr_t dec,
	output ctrlWord_t     ctrl,
	output logic          clr
);

	// datapath clear only while the FSM sits in reset
	assign clr = (state == reset);

	always_comb
	begin
		ctrl = ctrlIdle;
		case (state)
			// MAR <- PC
			fetchAddr:
			begin
				ctrl.marLd = 1'b1;
				ctrl.maSel = 2'b10;
				ctrl.md = 1'b1;
				ctrl.aluOp = 5'b10000;
			end
			// word read starts, PC advances
			fetchReq:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.rw = 1'b1;
				ctrl.mov = 1'b1;
				ctrl.typeData = 2'b10;
				ctrl.maSel = 2'b10;
				ctrl.mcSel = 3'b011;
				ctrl.md = 1'b1;
				ctrl.aluOp = 5'b10001;
			end
			fetchWait:
			begin
				ctrl.irLd = 1'b1;
				ctrl.rw = 1'b1;
				ctrl.mov = 1'b1;
				ctrl.typeData = 2'b10;
			end
			dpImmAlu:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.mbSel = 2'b01;
				ctrl.mcSel = 3'b100;
				ctrl.mfSel = 2'b11;
				ctrl.md = 1'b1;
				ctrl.tSel = 3'b001;
				ctrl.e = 1'b1;
				ctrl.aluOp = 5'b10011;
			end
			dpImmWrite:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.frLd = dec.sBit;
				ctrl.miSel = 2'b10;
				ctrl.mjSel = 2'b01;
				ctrl.tSel = 3'b100;
			end
			dpShift:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.frLd = dec.sBit;
				ctrl.mbSel = 2'b01;
				ctrl.mh = 1'b1;
				ctrl.miSel = 2'b01;
			end
			// LR <- PC before the target is formed
			branchLink:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.maSel = 2'b11;
				ctrl.mcSel = 3'b010;
				ctrl.md = 1'b1;
				ctrl.mjSel = 2'b01;
				ctrl.sSel = 6'b000100;
				ctrl.aluOp = 5'b10000;
			end
			// flags load unconditionally on every branch
			branchCalc:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.frLd = 1'b1;
				ctrl.mbSel = 2'b01;
				ctrl.mcSel = 3'b100;
				ctrl.md = 1'b1;
				ctrl.mfSel = 2'b11;
				ctrl.miSel = 2'b10;
				ctrl.mjSel = 2'b10;
				ctrl.e = 1'b1;
				ctrl.tSel = 3'b100;
				ctrl.aluOp = 5'b10011;
			end
			branchWrite:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.maSel = 2'b10;
				ctrl.mbSel = 2'b01;
				ctrl.mcSel = 3'b011;
				ctrl.md = 1'b1;
				ctrl.miSel = 2'b10;
				ctrl.mjSel = 2'b01;
				ctrl.tSel = 3'b101;
				ctrl.sSel = 6'b000100;
				ctrl.aluOp = 5'b00100;
			end
			// reset and decode keep every strobe low
			default:
				ctrl = ctrlIdle;
		endcase
	end

endmodule

// ==== rtl/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit
	import cuPkg::*;
(
	input  logic       CLK,
	input  logic       arstN,
	input  instrWord_t ir,
	input  logic       cond,
	input  logic       moc,
	output ctrlWord_t  ctrl,
	output logic       clr
);

	decodedInstr_t dec;
	cuState_t      state;

	instrDecoder uDecoder
	(
		.ir(ir),
		.dec(dec)
	);

	// cond and moc are seen by the sequencer only
	sequencer uSequencer
	(
		.CLK(CLK),
		.arstN(arstN),
		.dec(dec),
		.cond(cond),
		.moc(moc),
		.state(state)
	);

	microcodeDecode uMicrocode
	(
		.state(state),
		.dec(dec),
		.ctrl(ctrl),
		.clr(clr)
	);

endmodule

// ==== tests/controlUnit_props.sv ====
`timescale 1ns/1ps

module controlUnit_props
	import cuPkg::*;
(
	input logic      CLK,
	input logic      arstN,
	input logic      moc,
	input ctrlWord_t ctrl,
	input logic      clr
);

	// address load and IR load belong to different fetch states
	marIrExclusive: assert property (@(posedge CLK) disable iff (!arstN)
		!(ctrl.marLd && ctrl.irLd))
		else $error("marLd and irLd high in the same cycle");

	// datapath clear comes with an idle control word
	clrIdle: assert property (@(posedge CLK)
		clr |-> (ctrl == ctrlIdle))
		else $error("clr high with a nonzero control word");

	irLdHeld: assert property (@(posedge CLK) disable iff (!arstN)
		(ctrl.irLd && !moc) |=> ctrl.irLd)
		else $error("irLd dropped before moc was seen");

endmodule

// ctrl comes from microcodeDecode, moc goes to the sequencer
bind controlUnit controlUnit_props props
(
	.CLK(CLK),
	.arstN(arstN),
	.moc(moc),
	.ctrl(ctrl),
	.clr(clr)
);

// ==== tests/controlUnit_tb.sv ====
`timescale 1ns/1ps

module controlUnit_tb
	import cuPkg::*;
();

	localparam int halfPeriod = 2;
	localparam int resetCycles = 4;
	localparam int maxExecCycles = 12;

	logic       CLK;
	logic       arstN;
	instrWord_t ir;
	logic       cond;
	logic       moc;
	ctrlWord_t  ctrl;
	logic       clr;

	// one entry per stimulus line
	instrWord_t  wordQ[$];
	logic        condQ[$];
	int          delayQ[$];
	int          cyclesQ[$];
	int          frLdQ[$];
	int          rfLdQ[$];
	instrClass_t classQ[$];

	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	int limitCycles = 0;

	controlUnit dut
	(
		.CLK(CLK),
		.arstN(arstN),
		.ir(ir),
		.cond(cond),
		.moc(moc),
		.ctrl(ctrl),
		.clr(clr)
	);

	initial
	begin
		CLK = 1'b0;
		forever
			#halfPeriod CLK = ~CLK;
	end

	task automatic compareCtrl(input ctrlWord_t got, input ctrlWord_t exp, input string what);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s, ctrl %h, expected %h", $time, what, got, exp);
			errorCount++;
		end
	endtask

	task automatic compareClass(input instrClass_t got, input instrClass_t exp, input string what);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s, got %s, expected %s",
				$time, what, got.name(), exp.name());
			errorCount++;
		end
	endtask

	task automatic compareCount(input int got, input int exp, input string what);
		if (got != exp)
		begin
			$display("** Error at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
			errorCount++;
		end
	endtask

	task automatic reportTest(input int idx, input int startErrors, input string label);
		if (errorCount == startErrors)
		begin
			passCount++;
			$display("test %0d (%s): ok", idx, label);
		end
		else
		begin
			failCount++;
			$display("test %0d (%s): FAILED", idx, label);
		end
	endtask

	task automatic loadStimulus();
		int         fd;
		int         n;
		string      textLine;
		instrWord_t w;
		int         c;
		int         d;
		int         cyc;
		int         fr;
		int         rf;
		int         cls;
		fd = $fopen("tests/controlUnit_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file");
			errorCount++;
			return;
		end
		while (!$feof(fd))
		begin
			textLine = "";
			n = $fgets(textLine, fd);
			if (textLine.len() < 2 || textLine.substr(0, 0) == "#")
				continue;
			n = $sscanf(textLine, "%h %d %d %d %d %d %d", w, c, d, cyc, fr, rf, cls);
			if (n != 7)
			begin
				$display("malformed stimulus line: %s", textLine);
				errorCount++;
				continue;
			end
			wordQ.push_back(w);
			condQ.push_back(c[0]);
			// memory latency is the file delay plus 0 to 3 random cycles
			delayQ.push_back(d + int'($urandom % 4));
			cyclesQ.push_back(cyc);
			frLdQ.push_back(fr);
			rfLdQ.push_back(rf);
			classQ.push_back(instrClass_t'(cls[1:0]));
		end
		$fclose(fd);
	endtask

	task automatic checkReset();
		int startErrors;
		startErrors = errorCount;
		arstN = 1'b0;
		repeat (resetCycles)
		begin
			@(negedge CLK);
			compareCount(int'(clr), 1, "clr during reset");
			compareCtrl(ctrl, ctrlIdle, "ctrl during reset");
		end
		arstN = 1'b1;
		@(negedge CLK);
		// the address load comes before any other strobe
		compareCount(int'(ctrl.marLd), 1, "marLd after reset");
		compareCount(int'(ctrl.irLd) + int'(ctrl.rfLd) + int'(ctrl.frLd), 0, "strobes after reset");
		compareCount(int'(clr), 0, "clr after reset");
		reportTest(0, startErrors, "reset");
	endtask

	task automatic runTest(input int idx);
		int startErrors;
		int guard;
		int irCycles;
		int cycles;
		int frCount;
		int rfCount;
		startErrors = errorCount;
		guard = 0;
		while (!ctrl.irLd && guard < 4)
		begin
			@(negedge CLK);
			guard++;
		end
		if (!ctrl.irLd)
		begin
			$display("test %0d: irLd was never raised after the address load", idx + 1);
			errorCount++;
		end
		irCycles = 0;
		while (ctrl.irLd && irCycles <= delayQ[idx] + 2)
		begin
			// memory answers with the word once the latency is over
			if (irCycles == delayQ[idx])
			begin
				ir = wordQ[idx];
				cond = condQ[idx];
				moc = 1'b1;
			end
			irCycles++;
			@(negedge CLK);
		end
		moc = 1'b0;
		compareCount(irCycles, delayQ[idx] + 1, "irLd cycles");
		compareCtrl(ctrl, ctrlIdle, "decode cycle");
		compareClass(dut.dec.instrClass, classQ[idx], "decoded class");
		cycles = 1;
		frCount = 0;
		rfCount = 0;
		@(negedge CLK);
		while (!ctrl.marLd && cycles < maxExecCycles)
		begin
			cycles++;
			if (ctrl.frLd)
				frCount++;
			if (ctrl.rfLd)
				rfCount++;
			@(negedge CLK);
		end
		if (!ctrl.marLd)
		begin
			$display("test %0d: marLd did not come back within %0d cycles", idx + 1, cycles);
			errorCount++;
		end
		compareCount(cycles, cyclesQ[idx], "cycles from decode to marLd");
		compareCount(frCount, frLdQ[idx], "frLd pulses");
		compareCount(rfCount, rfLdQ[idx], "rfLd cycles");
		reportTest(idx + 1, startErrors, $sformatf("%h cond %0d", wordQ[idx], condQ[idx]));
	endtask

	initial
	begin
		int totalDelay;
		arstN = 1'b0;
		ir = '0;
		cond = 1'b0;
		moc = 1'b0;
		void'($urandom(33961));
		loadStimulus();
		totalDelay = 0;
		foreach (delayQ[i])
			totalDelay += delayQ[i];
		limitCycles = (totalDelay + 10) * wordQ.size() + 2 * resetCycles;
		if (wordQ.size() == 0)
		begin
			$display("no stimulus lines were read");
			errorCount++;
		end
		checkReset();
		for (int i = 0; i < wordQ.size(); i++)
			runTest(i);
		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			passCount + failCount, passCount, failCount, errorCount);
		if (errorCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// limit scales with the memory latencies in the stimulus
	initial
	begin
		wait (limitCycles > 0);
		repeat (limitCycles)
			@(posedge CLK);
		$display("watchdog expired after %0d cycles, the run did not finish", limitCycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== tests/controlUnit_stimulus.txt ====
# word cond mocDelay cyclesDecodeToMarLd frLdCount rfLdCount class
# class 0 dataImm, 1 dataShift, 2 branch, 3 unsupported; mocDelay is the base latency
e3b01005 1 0 3 1 2 0
e2810001 1 2 3 0 2 0
e2900001 1 5 3 1 2 0
e0910002 1 1 2 1 1 1
e0810002 1 3 2 0 1 1
e1b00000 1 0 2 1 1 1
ea000004 1 0 3 1 2 2
ea100008 1 1 3 1 2 2
eb000010 1 2 4 1 3 2
eb100020 1 3 4 1 3 2
e5910000 1 0 1 0 0 3
e5b10000 1 1 1 0 0 3
e7910002 1 4 1 0 0 3
e8bd0003 1 1 1 0 0 3
ed910100 1 0 1 0 0 3
ee010f10 1 2 1 0 0 3
e3b01005 0 1 1 0 0 0
e0910002 0 0 1 0 0 1
eb000010 0 2 1 0 0 2
ea000004 0 3 1 0 0 2
e5910000 0 1 1 0 0 3

// ==== flist.f ====
+incdir+rtl
rtl/cuPkg.sv
rtl/instrDecoder.sv
rtl/sequencer.sv
rtl/microcodeDecode.sv
rtl/controlUnit.sv
tests/controlUnit_props.sv
tests/controlUnit_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module controlUnit_tb \
	-f flist.f \
	-o controlUnit_sim

./obj_dir/controlUnit_sim | tee sim.log

if grep -qx "Simulation completed successfully" sim.log
then
	echo "run passed"
else
	echo "run did not pass, see sim.log"
	exit 1
fi
